//--- verilog/axi_bridge_consts.svh
`ifndef AXI_BRIDGE_CONSTS_SVH
`define AXI_BRIDGE_CONSTS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 64
`define STRB_W (`DATA_W / 8)

// axlen field and client length width
`define LEN_W 8

// longest burst the bridge issues
`define MAX_BEATS 8

// axburst codes
`define BURST_FIXED 2'b00
`define BURST_INCR 2'b01

// xresp codes
`define RESP_OKAY 2'b00
`define RESP_EXOKAY 2'b01
`define RESP_SLVERR 2'b10
`define RESP_DECERR 2'b11

`endif

//--- verilog/axi_bridge_pkg.sv
`default_nettype none

package axi_bridge_pkg;

  typedef enum logic [2:0] {
    wr_idle,
    wr_addr_data,   // single write, aw and w together
    wr_addr_burst,  // burst, address goes first
    wr_data_burst,
    wr_resp
  } wr_state_e;

  typedef enum logic [1:0] {
    rd_idle,
    rd_addr,
    rd_data
  } rd_state_e;

  typedef enum logic {
    client_fetch,
    client_data
  } client_e;

  typedef enum logic [2:0] {
    size_1 = 3'd0,
    size_2 = 3'd1,
    size_4 = 3'd2,
    size_8 = 3'd3
  } axi_size_e;

  // client one-hot byte count to axsize, widest bit wins
  function automatic axi_size_e size_code(input logic [3:0] size_onehot);
    axi_size_e code;
    if (size_onehot[3]) code = size_8;
    else if (size_onehot[2]) code = size_4;
    else if (size_onehot[1]) code = size_2;
    else code = size_1;
    return code;
  endfunction

endpackage

`default_nettype wire

//--- verilog/mem_read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_consts.svh"

module mem_read_arbiter (
  input  wire                clock,
  input  wire                reset,
  // instruction fetch client, reads only
  input  wire                fetch_req_i,
  input  wire [`ADDR_W-1:0]  fetch_addr_i,
  input  wire [`LEN_W-1:0]   fetch_len_i,
  // data client, read side
  input  wire                data_read_i,
  input  wire [`ADDR_W-1:0]  data_addr_i,
  input  wire [`LEN_W-1:0]   data_len_i,
  input  wire [3:0]          data_size_i,
  // from the read master
  input  wire                rd_beat_i,
  input  wire                rd_last_i,
  input  wire [`DATA_W-1:0]  rd_data_i,
  // to the read master
  output logic               rd_req_o,
  output logic [`ADDR_W-1:0] rd_addr_o,
  output logic [`LEN_W-1:0]  rd_len_o,
  output logic [3:0]         rd_size_o,
  // steered responses
  output logic               fetch_rvalid_o,
  output logic               fetch_rlast_o,
  output logic [`DATA_W-1:0] fetch_rdata_o,
  output logic               data_rvalid_o,
  output logic               data_rlast_o,
  output logic [`DATA_W-1:0] data_rdata_o
);

  axi_bridge_pkg::client_e owner;     // current owner while busy
  axi_bridge_pkg::client_e last_win;  // winner of the latest collision
  axi_bridge_pkg::client_e gnt;
  axi_bridge_pkg::client_e sel;
  logic busy;
  logic sel_req;
  logic to_fetch;
  logic to_data;

  // collisions take turns, otherwise whoever asks
  always_comb begin
    if (fetch_req_i && data_read_i) begin
      gnt = (last_win == axi_bridge_pkg::client_fetch) ? axi_bridge_pkg::client_data
                                                       : axi_bridge_pkg::client_fetch;
    end else if (fetch_req_i) begin
      gnt = axi_bridge_pkg::client_fetch;
    end else begin
      gnt = axi_bridge_pkg::client_data;
    end
  end

  assign sel     = busy ? owner : gnt;
  assign sel_req = (sel == axi_bridge_pkg::client_fetch) ? fetch_req_i : data_read_i;

  // dropped on the completion cycle so the old level is not reissued
  assign rd_req_o = sel_req & ~rd_last_i;

  always_comb begin
    if (sel == axi_bridge_pkg::client_fetch) begin
      rd_addr_o = fetch_addr_i;
      rd_len_o  = fetch_len_i;
      rd_size_o = 4'b1000;  // fetch is always a full word
    end else begin
      rd_addr_o = data_addr_i;
      rd_len_o  = data_len_i;
      rd_size_o = data_size_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy     <= 1'b0;
      owner    <= axi_bridge_pkg::client_data;
      last_win <= axi_bridge_pkg::client_data;  // fetch wins the first collision
    end else if (!busy) begin
      if (rd_req_o) begin
        busy  <= 1'b1;
        owner <= gnt;
        if (fetch_req_i && data_read_i) last_win <= gnt;
      end
    end else if (rd_last_i) begin
      busy <= 1'b0;
    end
  end

  // beats only go to the owner
  assign to_fetch = busy & (owner == axi_bridge_pkg::client_fetch);
  assign to_data  = busy & (owner == axi_bridge_pkg::client_data);

  assign fetch_rvalid_o = rd_beat_i & to_fetch;
  assign fetch_rlast_o  = rd_last_i & to_fetch;
  assign fetch_rdata_o  = rd_data_i;
  assign data_rvalid_o  = rd_beat_i & to_data;
  assign data_rlast_o   = rd_last_i & to_data;
  assign data_rdata_o   = rd_data_i;

endmodule

`default_nettype wire

//--- verilog/axi_write_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_consts.svh"

module axi_write_master (
  input  wire                clock,
  input  wire                reset,
  // client write side
  input  wire                wr_req_i,
  input  wire [`ADDR_W-1:0]  wr_addr_i,
  input  wire [`LEN_W-1:0]   wr_len_i,
  input  wire [3:0]          wr_size_i,  // one-hot byte count
  input  wire [`STRB_W-1:0]  wr_mask_i,
  input  wire [`DATA_W-1:0]  wr_data_i,
  output logic               wr_ack_o,
  output logic               wr_done_o,
  output logic [1:0]         wr_resp_o,
  // axi write channels
  input  wire                aw_ready_i,
  input  wire                w_ready_i,
  input  wire                b_valid_i,
  input  wire [1:0]          b_resp_i,
  output logic               aw_valid_o,
  output logic [`ADDR_W-1:0] aw_addr_o,
  output logic [`LEN_W-1:0]  aw_len_o,
  output logic [2:0]         aw_size_o,
  output logic [1:0]         aw_burst_o,
  output logic               w_valid_o,
  output logic [`DATA_W-1:0] w_data_o,
  output logic [`STRB_W-1:0] w_strb_o,
  output logic               w_last_o,
  output logic               b_ready_o
);

  localparam int CNT_W = $clog2(`MAX_BEATS);

  axi_bridge_pkg::wr_state_e state;
  logic [CNT_W-1:0] beat_cnt;   // index of the beat being loaded
  logic             beat_gap;   // client swaps in the next beat
  logic             aw_hs;
  logic             w_hs;
  logic             b_hs;
  logic             last_beat;

  assign aw_hs = aw_valid_o & aw_ready_i;
  assign w_hs  = w_valid_o & w_ready_i;
  assign b_hs  = b_valid_i & b_ready_o;

  assign last_beat  = (beat_cnt == aw_len_o[CNT_W-1:0]);
  assign aw_burst_o = `BURST_INCR;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= axi_bridge_pkg::wr_idle;
      aw_valid_o <= 1'b0;
      w_valid_o  <= 1'b0;
      w_last_o   <= 1'b0;
      b_ready_o  <= 1'b0;
      wr_ack_o   <= 1'b0;
      wr_done_o  <= 1'b0;
      wr_resp_o  <= `RESP_OKAY;
      beat_cnt   <= '0;
      beat_gap   <= 1'b0;
    end else begin
      wr_ack_o  <= 1'b0;
      wr_done_o <= 1'b0;
      case (state)
        axi_bridge_pkg::wr_idle: begin
          if (wr_req_i && !wr_done_o) begin  // no reissue on the done cycle
            aw_valid_o <= 1'b1;
            aw_addr_o  <= wr_addr_i;
            aw_len_o   <= wr_len_i;
            aw_size_o  <= axi_bridge_pkg::size_code(wr_size_i);
            beat_cnt   <= '0;
            beat_gap   <= 1'b0;
            if (wr_len_i == '0) begin
              w_valid_o <= 1'b1;
              w_last_o  <= 1'b1;
              w_data_o  <= wr_data_i;
              w_strb_o  <= wr_mask_i;
              state     <= axi_bridge_pkg::wr_addr_data;
            end else begin
              state <= axi_bridge_pkg::wr_addr_burst;
            end
          end
        end
        axi_bridge_pkg::wr_addr_data: begin
          if (aw_hs) aw_valid_o <= 1'b0;
          if (w_hs) begin
            w_valid_o <= 1'b0;
            w_last_o  <= 1'b0;
            wr_ack_o  <= 1'b1;
          end
          // both channels done, either earlier or right now
          if ((!aw_valid_o || aw_ready_i) && (!w_valid_o || w_ready_i)) begin
            b_ready_o <= 1'b1;
            state     <= axi_bridge_pkg::wr_resp;
          end
        end
        axi_bridge_pkg::wr_addr_burst: begin
          if (aw_hs) begin
            aw_valid_o <= 1'b0;
            w_valid_o  <= 1'b1;  // first beat is already on the client bus
            w_last_o   <= last_beat;
            w_data_o   <= wr_data_i;
            w_strb_o   <= wr_mask_i;
            state      <= axi_bridge_pkg::wr_data_burst;
          end
        end
        axi_bridge_pkg::wr_data_burst: begin
          if (w_hs) begin
            w_valid_o <= 1'b0;
            w_last_o  <= 1'b0;
            wr_ack_o  <= 1'b1;
            beat_cnt  <= beat_cnt + 1'b1;
            if (w_last_o) begin
              b_ready_o <= 1'b1;
              state     <= axi_bridge_pkg::wr_resp;
            end else begin
              beat_gap <= 1'b1;
            end
          end else if (!w_valid_o) begin
            if (beat_gap) begin
              beat_gap <= 1'b0;
            end else begin
              w_valid_o <= 1'b1;
              w_last_o  <= last_beat;
              w_data_o  <= wr_data_i;
              w_strb_o  <= wr_mask_i;
            end
          end
        end
        axi_bridge_pkg::wr_resp: begin
          if (b_hs) begin
            b_ready_o <= 1'b0;
            wr_done_o <= 1'b1;
            wr_resp_o <= b_resp_i;  // reported as is
            state     <= axi_bridge_pkg::wr_idle;
          end
        end
        default: state <= axi_bridge_pkg::wr_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/axi_read_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_consts.svh"

module axi_read_master (
  input  wire                clock,
  input  wire                reset,
  // request from the arbiter
  input  wire                rd_req_i,
  input  wire [`ADDR_W-1:0]  rd_addr_i,
  input  wire [`LEN_W-1:0]   rd_len_i,
  input  wire [3:0]          rd_size_i,
  // axi read channels
  input  wire                ar_ready_i,
  input  wire                r_valid_i,
  input  wire [`DATA_W-1:0]  r_data_i,
  input  wire                r_last_i,
  // beat pulses back to the arbiter
  output logic               rd_beat_o,
  output logic               rd_last_o,
  output logic [`DATA_W-1:0] rd_data_o,
  output logic               ar_valid_o,
  output logic [`ADDR_W-1:0] ar_addr_o,
  output logic [`LEN_W-1:0]  ar_len_o,
  output logic [2:0]         ar_size_o,
  output logic [1:0]         ar_burst_o,
  output logic               r_ready_o
);

  axi_bridge_pkg::rd_state_e state;

  assign ar_burst_o = `BURST_INCR;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= axi_bridge_pkg::rd_idle;
      ar_valid_o <= 1'b0;
      r_ready_o  <= 1'b0;
      rd_beat_o  <= 1'b0;
      rd_last_o  <= 1'b0;
    end else begin
      rd_beat_o <= 1'b0;
      rd_last_o <= 1'b0;
      case (state)
        axi_bridge_pkg::rd_idle: begin
          // last pulse cycle still sees the finished request
          if (rd_req_i && !rd_last_o) begin
            ar_valid_o <= 1'b1;
            ar_addr_o  <= rd_addr_i;
            ar_len_o   <= rd_len_i;
            ar_size_o  <= axi_bridge_pkg::size_code(rd_size_i);
            state      <= axi_bridge_pkg::rd_addr;
          end
        end
        axi_bridge_pkg::rd_addr: begin
          if (ar_ready_i) begin  // ar_valid_o is high in this state
            ar_valid_o <= 1'b0;
            r_ready_o  <= 1'b1;
            state      <= axi_bridge_pkg::rd_data;
          end
        end
        axi_bridge_pkg::rd_data: begin
          if (r_valid_i) begin
            rd_beat_o <= 1'b1;
            rd_last_o <= r_last_i;
            rd_data_o <= r_data_i;
            if (r_last_i) begin
              r_ready_o <= 1'b0;
              state     <= axi_bridge_pkg::rd_idle;
            end
          end
        end
        default: state <= axi_bridge_pkg::rd_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/axi_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_consts.svh"

module axi_bridge_top (
  input  wire                 clock,
  input  wire                 reset,
  // fetch client
  input  wire                 fetch_req_i,
  input  wire [`ADDR_W-1:0]   fetch_addr_i,
  input  wire [`LEN_W-1:0]    fetch_len_i,
  output wire                 fetch_rvalid_o,
  output wire                 fetch_rlast_o,
  output wire [`DATA_W-1:0]   fetch_rdata_o,
  // data client
  input  wire                 data_read_i,
  input  wire                 data_write_i,
  input  wire [`ADDR_W-1:0]   data_addr_i,
  input  wire [`LEN_W-1:0]    data_len_i,
  input  wire [3:0]           data_size_i,
  input  wire [`STRB_W-1:0]   data_wmask_i,
  input  wire [`DATA_W-1:0]   data_wdata_i,
  output wire                 data_rvalid_o,
  output wire                 data_rlast_o,
  output wire [`DATA_W-1:0]   data_rdata_o,
  output wire                 data_wack_o,
  output wire                 data_wdone_o,
  output wire [1:0]           data_wresp_o,
  // axi master
  input  wire                 aw_ready_i,
  output wire                 aw_valid_o,
  output wire [`ADDR_W-1:0]   aw_addr_o,
  output wire [`LEN_W-1:0]    aw_len_o,
  output wire [2:0]           aw_size_o,
  output wire [1:0]           aw_burst_o,
  input  wire                 w_ready_i,
  output wire                 w_valid_o,
  output wire [`DATA_W-1:0]   w_data_o,
  output wire [`STRB_W-1:0]   w_strb_o,
  output wire                 w_last_o,
  input  wire                 b_valid_i,
  input  wire [1:0]           b_resp_i,
  output wire                 b_ready_o,
  input  wire                 ar_ready_i,
  output wire                 ar_valid_o,
  output wire [`ADDR_W-1:0]   ar_addr_o,
  output wire [`LEN_W-1:0]    ar_len_o,
  output wire [2:0]           ar_size_o,
  output wire [1:0]           ar_burst_o,
  input  wire                 r_valid_i,
  input  wire [`DATA_W-1:0]   r_data_i,
  input  wire                 r_last_i,
  output wire                 r_ready_o
);

  // arbiter to read master
  wire               rd_req;
  wire [`ADDR_W-1:0] rd_addr;
  wire [`LEN_W-1:0]  rd_len;
  wire [3:0]         rd_size;
  wire               rd_beat;
  wire               rd_last;
  wire [`DATA_W-1:0] rd_data;

  mem_read_arbiter arb_i (
    .clock(clock), .reset(reset),
    .fetch_req_i(fetch_req_i), .fetch_addr_i(fetch_addr_i), .fetch_len_i(fetch_len_i),
    .data_read_i(data_read_i), .data_addr_i(data_addr_i), .data_len_i(data_len_i),
    .data_size_i(data_size_i),
    .rd_beat_i(rd_beat), .rd_last_i(rd_last), .rd_data_i(rd_data),
    .rd_req_o(rd_req), .rd_addr_o(rd_addr), .rd_len_o(rd_len), .rd_size_o(rd_size),
    .fetch_rvalid_o(fetch_rvalid_o), .fetch_rlast_o(fetch_rlast_o),
    .fetch_rdata_o(fetch_rdata_o),
    .data_rvalid_o(data_rvalid_o), .data_rlast_o(data_rlast_o), .data_rdata_o(data_rdata_o)
  );

  axi_read_master rd_i (
    .clock(clock), .reset(reset),
    .rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_len_i(rd_len), .rd_size_i(rd_size),
    .ar_ready_i(ar_ready_i), .r_valid_i(r_valid_i), .r_data_i(r_data_i), .r_last_i(r_last_i),
    .rd_beat_o(rd_beat), .rd_last_o(rd_last), .rd_data_o(rd_data),
    .ar_valid_o(ar_valid_o), .ar_addr_o(ar_addr_o), .ar_len_o(ar_len_o),
    .ar_size_o(ar_size_o), .ar_burst_o(ar_burst_o), .r_ready_o(r_ready_o)
  );

  // writes come only from the data client
  axi_write_master wr_i (
    .clock(clock), .reset(reset),
    .wr_req_i(data_write_i), .wr_addr_i(data_addr_i), .wr_len_i(data_len_i),
    .wr_size_i(data_size_i), .wr_mask_i(data_wmask_i), .wr_data_i(data_wdata_i),
    .wr_ack_o(data_wack_o), .wr_done_o(data_wdone_o), .wr_resp_o(data_wresp_o),
    .aw_ready_i(aw_ready_i), .w_ready_i(w_ready_i), .b_valid_i(b_valid_i),
    .b_resp_i(b_resp_i),
    .aw_valid_o(aw_valid_o), .aw_addr_o(aw_addr_o), .aw_len_o(aw_len_o),
    .aw_size_o(aw_size_o), .aw_burst_o(aw_burst_o),
    .w_valid_o(w_valid_o), .w_data_o(w_data_o), .w_strb_o(w_strb_o), .w_last_o(w_last_o),
    .b_ready_o(b_ready_o)
  );

endmodule

`default_nettype wire

//--- verif/axi_slave_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_consts.svh"

module axi_slave_mem (
  input  wire                clock,
  input  wire                reset,
  input  wire                heavy_i,  // stall most cycles
  input  wire                aw_valid_i,
  input  wire [`ADDR_W-1:0]  aw_addr_i,
  output logic               aw_ready_o,
  input  wire                w_valid_i,
  input  wire [`DATA_W-1:0]  w_data_i,
  input  wire [`STRB_W-1:0]  w_strb_i,
  input  wire                w_last_i,
  output logic               w_ready_o,
  output logic               b_valid_o,
  output logic [1:0]         b_resp_o,
  input  wire                b_ready_i,
  input  wire                ar_valid_i,
  input  wire [`ADDR_W-1:0]  ar_addr_i,
  input  wire [`LEN_W-1:0]   ar_len_i,
  output logic               ar_ready_o,
  output logic               r_valid_o,
  output logic [`DATA_W-1:0] r_data_o,
  output logic               r_last_o,
  input  wire                r_ready_i
);

  logic [`DATA_W-1:0] mem [0:255];  // 2 KB, word index is addr[10:3]
  logic [`ADDR_W-1:0] waddr;
  logic [`ADDR_W-1:0] raddr;
  logic [`LEN_W-1:0]  rlen;
  logic [`LEN_W-1:0]  rcnt;
  logic               aw_busy;
  logic               r_busy;

  // true most cycles when light, rarely when heavy
  function automatic logic go();
    logic [1:0] r;
    r = 2'($urandom);
    return heavy_i ? (r == 2'd0) : (r != 2'd0);
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {(32'(i * 8) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f, ~32'(i * 8)};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      b_resp_o   <= `RESP_OKAY;
      aw_busy    <= 1'b0;
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_last_o   <= 1'b0;
      r_busy     <= 1'b0;
    end else begin
      aw_ready_o <= !aw_busy && go();
      w_ready_o  <= aw_busy && !b_valid_o && go();
      ar_ready_o <= !r_busy && go();
      if (aw_valid_i && aw_ready_o) begin
        waddr      <= aw_addr_i;
        aw_busy    <= 1'b1;
        aw_ready_o <= 1'b0;
      end
      if (w_valid_i && w_ready_o) begin
        for (int b = 0; b < `STRB_W; b++) begin
          if (w_strb_i[b]) mem[waddr[10:3]][b*8 +: 8] <= w_data_i[b*8 +: 8];
        end
        waddr <= waddr + 8;
        if (w_last_i) begin
          b_valid_o <= 1'b1;
          w_ready_o <= 1'b0;
        end
      end
      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
        aw_busy   <= 1'b0;
      end
      if (ar_valid_i && ar_ready_o) begin
        raddr      <= ar_addr_i;
        rlen       <= ar_len_i;
        rcnt       <= '0;
        r_busy     <= 1'b1;
        ar_ready_o <= 1'b0;
      end
      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        raddr     <= raddr + 8;
        rcnt      <= rcnt + 1'b1;
        if (r_last_o) r_busy <= 1'b0;
      end else if (r_busy && !r_valid_o && go()) begin
        r_valid_o <= 1'b1;
        r_data_o  <= mem[raddr[10:3]];
        r_last_o  <= (rcnt == rlen);
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/axi_bridge_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_consts.svh"

module axi_bridge_checker (
  input wire               clock,
  input wire               reset,
  input wire               aw_valid_o,
  input wire               aw_ready_i,
  input wire [`ADDR_W-1:0] aw_addr_o,
  input wire [`LEN_W-1:0]  aw_len_o,
  input wire               w_valid_o,
  input wire               w_ready_i,
  input wire [`DATA_W-1:0] w_data_o,
  input wire [`STRB_W-1:0] w_strb_o,
  input wire               w_last_o,
  input wire               ar_valid_o,
  input wire               ar_ready_i,
  input wire [`ADDR_W-1:0] ar_addr_o,
  input wire [`LEN_W-1:0]  ar_len_o,
  input wire               fetch_req_i,
  input wire               fetch_rvalid_o,
  input wire               data_read_i,
  input wire               data_rvalid_o
);

  logic [`LEN_W-1:0] w_cnt;  // beats already accepted in this burst
  int fail_cnt = 0;          // failed assertions so far

  always_ff @(posedge clock) begin
    if (reset) begin
      w_cnt <= '0;
    end else if (w_valid_o && w_ready_i) begin
      w_cnt <= w_last_o ? '0 : w_cnt + 1'b1;
    end
  end

  aw_stable: assert property (@(posedge clock) disable iff (reset)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o) && $stable(aw_len_o))
    else begin
      fail_cnt++;
      $error("aw payload changed while stalled");
    end

  w_stable: assert property (@(posedge clock) disable iff (reset)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_strb_o)
      && $stable(w_last_o))
    else begin
      fail_cnt++;
      $error("w payload changed while stalled");
    end

  ar_stable: assert property (@(posedge clock) disable iff (reset)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) && $stable(ar_len_o))
    else begin
      fail_cnt++;
      $error("ar payload changed while stalled");
    end

  // awlen stays on the bus after the aw handshake
  w_count: assert property (@(posedge clock) disable iff (reset)
    w_valid_o && w_ready_i && w_last_o |-> w_cnt == aw_len_o)
    else begin
      fail_cnt++;
      $error("wlast beat count differs from awlen");
    end

  fetch_owner: assert property (@(posedge clock) disable iff (reset)
    fetch_rvalid_o |-> fetch_req_i)
    else begin
      fail_cnt++;
      $error("fetch beat without a fetch request");
    end

  data_owner: assert property (@(posedge clock) disable iff (reset)
    data_rvalid_o |-> data_read_i)
    else begin
      fail_cnt++;
      $error("data beat without a data read");
    end

endmodule

bind axi_bridge_top axi_bridge_checker chk_i (.*);

`default_nettype wire

//--- verif/axi_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_bridge_consts.svh"

module axi_bridge_tb;

  localparam int N_TRANS = 2 * 20;  // transactions per pass, two passes
  localparam int LIMIT   = N_TRANS * `MAX_BEATS * 48;

  logic clock = 1'b0;
  logic reset;
  logic heavy;
  logic fetch_req;
  logic [`ADDR_W-1:0] fetch_addr;
  logic [`LEN_W-1:0] fetch_len;
  logic data_read;
  logic data_write;
  logic [`ADDR_W-1:0] data_addr;
  logic [`LEN_W-1:0] data_len;
  logic [3:0] data_size;
  logic [`STRB_W-1:0] data_wmask;
  logic [`DATA_W-1:0] data_wdata;
  wire fetch_rvalid, fetch_rlast, data_rvalid, data_rlast, data_wack, data_wdone;
  wire [`DATA_W-1:0] fetch_rdata, data_rdata;
  wire [1:0] data_wresp;
  wire aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
  wire ar_valid, ar_ready, r_valid, r_ready, r_last;
  wire [`ADDR_W-1:0] aw_addr, ar_addr;
  wire [`LEN_W-1:0] aw_len, ar_len;
  wire [2:0] aw_size, ar_size;
  wire [1:0] aw_burst, ar_burst, b_resp;
  wire [`DATA_W-1:0] w_data, r_data;
  wire [`STRB_W-1:0] w_strb;

  logic [`DATA_W-1:0] shadow [logic [`ADDR_W-1:0]];  // written words
  string test_name = "reset";
  int errors = 0;
  int cycles = 0;
  int salt = 0;
  logic [`ADDR_W-1:0] fetch_base, data_base;
  int fetch_beat, data_beat, fetch_last_idx, data_last_idx;
  axi_bridge_pkg::client_e coll_prev = axi_bridge_pkg::client_data;
  bit coll_seen = 0;
  bit coll_open = 0;

  always #2 clock = ~clock;

  axi_bridge_top dut_i (
    .clock(clock), .reset(reset),
    .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr), .fetch_len_i(fetch_len),
    .fetch_rvalid_o(fetch_rvalid), .fetch_rlast_o(fetch_rlast), .fetch_rdata_o(fetch_rdata),
    .data_read_i(data_read), .data_write_i(data_write), .data_addr_i(data_addr),
    .data_len_i(data_len), .data_size_i(data_size), .data_wmask_i(data_wmask),
    .data_wdata_i(data_wdata), .data_rvalid_o(data_rvalid), .data_rlast_o(data_rlast),
    .data_rdata_o(data_rdata), .data_wack_o(data_wack), .data_wdone_o(data_wdone),
    .data_wresp_o(data_wresp),
    .aw_ready_i(aw_ready), .aw_valid_o(aw_valid), .aw_addr_o(aw_addr), .aw_len_o(aw_len),
    .aw_size_o(aw_size), .aw_burst_o(aw_burst),
    .w_ready_i(w_ready), .w_valid_o(w_valid), .w_data_o(w_data), .w_strb_o(w_strb),
    .w_last_o(w_last), .b_valid_i(b_valid), .b_resp_i(b_resp), .b_ready_o(b_ready),
    .ar_ready_i(ar_ready), .ar_valid_o(ar_valid), .ar_addr_o(ar_addr), .ar_len_o(ar_len),
    .ar_size_o(ar_size), .ar_burst_o(ar_burst),
    .r_valid_i(r_valid), .r_data_i(r_data), .r_last_i(r_last), .r_ready_o(r_ready)
  );

  axi_slave_mem mem_i (
    .clock(clock), .reset(reset), .heavy_i(heavy),
    .aw_valid_i(aw_valid), .aw_addr_i(aw_addr), .aw_ready_o(aw_ready),
    .w_valid_i(w_valid), .w_data_i(w_data), .w_strb_i(w_strb), .w_last_i(w_last),
    .w_ready_o(w_ready), .b_valid_o(b_valid), .b_resp_o(b_resp), .b_ready_i(b_ready),
    .ar_valid_i(ar_valid), .ar_addr_i(ar_addr), .ar_len_i(ar_len), .ar_ready_o(ar_ready),
    .r_valid_o(r_valid), .r_data_o(r_data), .r_last_o(r_last), .r_ready_i(r_ready)
  );

  // power-on contents, a function of the full word address
  function automatic logic [`DATA_W-1:0] ref_word(input logic [`ADDR_W-1:0] addr);
    logic [`ADDR_W-1:0] a;
    a = {addr[`ADDR_W-1:3], 3'b000};
    if (shadow.exists(a)) return shadow[a];
    return {(a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f, ~a};
  endfunction

  function automatic logic [`DATA_W-1:0] beat_data(input logic [`ADDR_W-1:0] addr);
    return {(addr * 32'h0100_0193) ^ 32'(salt), addr ^ ~32'(salt)};
  endfunction

  // axsize is log2 of the byte count
  function automatic logic [2:0] axsize_of(input logic [3:0] bytes);
    case (bytes)
      4'b0001: return 3'd0;
      4'b0010: return 3'd1;
      4'b0100: return 3'd2;
      default: return 3'd3;
    endcase
  endfunction

  // byte lanes under the mask replace the old bytes
  function automatic void apply_write(input logic [`ADDR_W-1:0] addr,
                                      input logic [`DATA_W-1:0] data,
                                      input logic [`STRB_W-1:0] mask);
    logic [`DATA_W-1:0] w;
    w = ref_word(addr);
    for (int b = 0; b < `STRB_W; b++) begin
      if (mask[b]) w[b*8 +: 8] = data[b*8 +: 8];
    end
    shadow[{addr[`ADDR_W-1:3], 3'b000}] = w;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // collision winners take turns
  task automatic note_first(input axi_bridge_pkg::client_e who);
    if (coll_open) begin
      if (coll_seen) begin
        check_value({test_name, " grant"},
                    64'((coll_prev == axi_bridge_pkg::client_fetch) ?
                        axi_bridge_pkg::client_data : axi_bridge_pkg::client_fetch),
                    64'(who));
      end
      coll_prev = who;
      coll_seen = 1;
      coll_open = 0;
    end
  endtask

  // compare every beat against the reference model
  always @(posedge clock) begin
    if (fetch_rvalid) begin
      if (fetch_beat == 0) note_first(axi_bridge_pkg::client_fetch);
      check_value({test_name, " fetch data"}, ref_word(fetch_base + 8 * fetch_beat),
                  fetch_rdata);
      check_value({test_name, " fetch last"}, 64'(fetch_beat == fetch_last_idx),
                  64'(fetch_rlast));
      fetch_beat++;
    end
    if (data_rvalid) begin
      if (data_beat == 0) note_first(axi_bridge_pkg::client_data);
      check_value({test_name, " data"}, ref_word(data_base + 8 * data_beat), data_rdata);
      check_value({test_name, " data last"}, 64'(data_beat == data_last_idx),
                  64'(data_rlast));
      data_beat++;
    end
  end

  // address channels carry the client's request
  always @(posedge clock) begin
    if (ar_valid && ar_ready) begin
      if (fetch_req && ar_addr == fetch_addr) begin
        check_value({test_name, " ar len"}, 64'(fetch_len), 64'(ar_len));
        check_value({test_name, " ar size"}, 64'(axsize_of(4'b1000)), 64'(ar_size));
      end else begin
        check_value({test_name, " ar addr"}, 64'(data_addr), 64'(ar_addr));
        check_value({test_name, " ar len"}, 64'(data_len), 64'(ar_len));
        check_value({test_name, " ar size"}, 64'(axsize_of(data_size)), 64'(ar_size));
      end
      check_value({test_name, " ar burst"}, 64'(`BURST_INCR), 64'(ar_burst));
    end
    if (aw_valid && aw_ready) begin
      check_value({test_name, " aw addr"}, 64'(data_addr), 64'(aw_addr));
      check_value({test_name, " aw len"}, 64'(data_len), 64'(aw_len));
      check_value({test_name, " aw size"}, 64'(axsize_of(data_size)), 64'(aw_size));
      check_value({test_name, " aw burst"}, 64'(`BURST_INCR), 64'(aw_burst));
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout, the bridge stopped finishing requests after %0d cycles", cycles);
      $display("tests failed");
      $fatal(1);
    end else if (dut_i.chk_i.fail_cnt != 0) begin
      $display("a bus protocol assertion failed in %s", test_name);
      $display("tests failed");
      $fatal(1);
    end
  end

  task automatic read_data(input logic [`ADDR_W-1:0] addr, input int len,
                           input logic [3:0] size);
    @(posedge clock);
    data_base = addr;
    data_beat = 0;
    data_last_idx = len;
    data_read <= 1'b1;
    data_addr <= addr;
    data_len  <= `LEN_W'(len);
    data_size <= size;
    do @(posedge clock); while (!(data_rvalid && data_rlast));
    data_read <= 1'b0;
  endtask

  task automatic fetch_burst(input logic [`ADDR_W-1:0] addr, input int len);
    @(posedge clock);
    fetch_base = addr;
    fetch_beat = 0;
    fetch_last_idx = len;
    fetch_req  <= 1'b1;
    fetch_addr <= addr;
    fetch_len  <= `LEN_W'(len);
    do @(posedge clock); while (!(fetch_rvalid && fetch_rlast));
    fetch_req <= 1'b0;
  endtask

  task automatic write_burst(input logic [`ADDR_W-1:0] addr, input int len,
                             input logic [`STRB_W-1:0] mask);
    int beat;
    bit done;
    beat = 0;
    done = 0;
    @(posedge clock);
    data_write <= 1'b1;
    data_addr  <= addr;
    data_len   <= `LEN_W'(len);
    data_size  <= 4'b1000;
    data_wmask <= mask;
    data_wdata <= beat_data(addr);
    while (!done) begin
      @(posedge clock);
      if (data_wack) begin
        apply_write(addr + 8 * beat, beat_data(addr + 8 * beat), mask);
        beat++;
        if (beat <= len) data_wdata <= beat_data(addr + 8 * beat);
      end
      if (data_wdone) begin
        check_value({test_name, " wresp"}, 64'(`RESP_OKAY), 64'(data_wresp));
        check_value({test_name, " wack count"}, 64'(len + 1), 64'(beat));
        data_write <= 1'b0;
        done = 1;
      end
    end
  endtask

  task automatic run_all();
    test_name = "single reads";
    read_data(32'h40, 0, 4'b0001);
    read_data(32'h48, 0, 4'b0010);
    read_data(32'h50, 0, 4'b0100);
    read_data(32'h58, 0, 4'b1000);
    test_name = "fetch burst";
    fetch_burst(32'h100, 7);
    test_name = "masked write";
    write_burst(32'h40, 0, 8'b0011_0101);
    read_data(32'h40, 0, 4'b1000);
    test_name = "burst writes";
    write_burst(32'h200, 1, 8'hff);
    read_data(32'h200, 1, 4'b1000);
    write_burst(32'h300, 7, 8'hf3);
    fetch_burst(32'h300, 7);
    test_name = "collisions";
    for (int k = 0; k < 4; k++) begin
      coll_open = 1;
      fork
        fetch_burst(32'h400 + 64 * k, 3);
        read_data(32'h600 + 16 * k, 1, 4'b1000);
      join
    end
  endtask

  initial begin
    void'($urandom(32'hfd27));
    reset      <= 1'b1;
    heavy      <= 1'b0;
    fetch_req  <= 1'b0;
    fetch_addr <= '0;
    fetch_len  <= '0;
    data_read  <= 1'b0;
    data_write <= 1'b0;
    data_addr  <= '0;
    data_len   <= '0;
    data_size  <= 4'b1000;
    data_wmask <= '0;
    data_wdata <= '0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    salt = 32'h1357;
    run_all();
    @(posedge clock);
    heavy <= 1'b1;  // second pass under back-pressure
    salt = 32'h2468;
    run_all();
    repeat (10) @(posedge clock);
    if (errors == 0 && dut_i.chk_i.fail_cnt == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/axi_bridge_pkg.sv
verilog/mem_read_arbiter.sv
verilog/axi_write_master.sv
verilog/axi_read_master.sv
verilog/axi_bridge_top.sv
verif/axi_slave_mem.sv
verif/axi_bridge_checker.sv
verif/axi_bridge_tb.sv
